/* ByteFifo.sv */
`timescale 1ns/10ps
`default_nettype none

module ByteFifo import KeyboardPkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          fifoWriteRequest,
    input  UartFifoData_t fifoInData,
    input  logic          fifoReadRequest,
    output UartFifoData_t fifoOutData,
    output logic          fifoEmpty,
    output logic          fifoFull
);

    UartFifoData_t            mem [FifoDepth];
    logic [FifoAddrWidth-1:0] writePtr;
    logic [FifoAddrWidth-1:0] readPtr;
    logic [FifoAddrWidth:0]   count;
    logic                     doWrite;
    logic                     doRead;

    assign fifoEmpty = (count == '0);
    assign fifoFull = (count == (FifoAddrWidth + 1)'(FifoDepth));
    assign doWrite = fifoWriteRequest && !fifoFull;
    assign doRead = fifoReadRequest && !fifoEmpty;
    assign fifoOutData = mem[readPtr];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[writePtr] <= fifoInData;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) writePtr <= writePtr + 1'b1;
            if (doRead) readPtr <= readPtr + 1'b1;
            if (doWrite && !doRead) count <= count + 1'b1;
            else if (doRead && !doWrite) count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* KeyboardPkg.sv */
`default_nettype none

package KeyboardPkg;

    typedef logic [7:0] Scancode_t;
    typedef logic [7:0] UartFifoData_t;

    // Prefixes and modifier keys, scancode set 2
    localparam Scancode_t BreakCode = 8'hF0;
    localparam Scancode_t SpecialCode = 8'hE0;
    localparam Scancode_t LeftShiftCode = 8'h12;
    localparam Scancode_t RightShiftCode = 8'h59;
    localparam Scancode_t LeftCtrlCode = 8'h14;

    // Extended arrow keys, sent after E0
    localparam Scancode_t ArrowUpCode = 8'h75;
    localparam Scancode_t ArrowDownCode = 8'h72;
    localparam Scancode_t ArrowLeftCode = 8'h6B;
    localparam Scancode_t ArrowRightCode = 8'h74;

    localparam int FifoDepth = 16;
    localparam int FifoAddrWidth = $clog2(FifoDepth);

    localparam int ClocksPerBit = 16;
    localparam int BaudWidth = $clog2(ClocksPerBit);

    // PS/2 clock high this long cancels a partial frame
    localparam int Ps2IdleLimit = 2000;
    localparam int Ps2IdleWidth = $clog2(Ps2IdleLimit + 1);

endpackage

`default_nettype wire

/* Makefile */
TOP := Ps2UartBridgeTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f Ps2UartBridge.f
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* Ps2Receiver.sv */
`timescale 1ns/10ps
`default_nettype none

module Ps2Receiver import KeyboardPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      ps2Clk,
    input  logic      ps2Data,
    output Scancode_t scancode,
    output logic      scancodeDone,
    output logic      ps2Error
);

    logic [1:0]              clkSync;
    logic [1:0]              dataSync;
    logic                    clkPrev;
    logic                    fallEdge;
    logic [3:0]              bitCount;
    logic [9:0]              frameBits;
    logic [Ps2IdleWidth-1:0] idleCount;
    logic                    idleExpired;
    logic                    frameGood;

    assign fallEdge = clkPrev & ~clkSync[1];
    assign idleExpired = (idleCount == Ps2IdleWidth'(Ps2IdleLimit));

    // Start low, odd parity over data plus parity bit, stop high on the incoming bit
    assign frameGood = ~frameBits[0] & (^frameBits[9:1]) & dataSync[1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clkSync <= 2'b11;
            dataSync <= 2'b11;
            clkPrev <= 1'b1;
        end else begin
            clkSync <= {clkSync[0], ps2Clk};
            dataSync <= {dataSync[0], ps2Data};
            clkPrev <= clkSync[1];
        end
    end

    // Holds start, data and parity once ten bits are in
    always_ff @(posedge clk) begin
        if (fallEdge) begin
            frameBits <= {dataSync[1], frameBits[9:1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bitCount <= '0;
            idleCount <= '0;
            scancode <= '0;
            scancodeDone <= 1'b0;
            ps2Error <= 1'b0;
        end else begin
            scancodeDone <= 1'b0;
            ps2Error <= 1'b0;

            if (!clkSync[1]) begin
                idleCount <= '0;
            end else if (!idleExpired) begin
                idleCount <= idleCount + 1'b1;
            end

            if (fallEdge) begin
                if (bitCount == 4'd10) begin
                    bitCount <= '0;
                    if (frameGood) begin
                        scancode <= frameBits[8:1];
                        scancodeDone <= 1'b1;
                    end else begin
                        ps2Error <= 1'b1;
                    end
                end else begin
                    bitCount <= bitCount + 4'd1;
                end
            end else if (idleExpired) begin
                bitCount <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* Ps2Translator.sv */
`timescale 1ns/10ps
`default_nettype none

module Ps2Translator import KeyboardPkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          scancodeDone,
    input  Scancode_t     scancode,
    input  logic          fifoFull,
    output logic          fifoWriteRequest,
    output UartFifoData_t fifoInData
);

    typedef enum logic [3:0] {
        normal, breakNormal, specialNormal,
        shiftHeld, breakShift, specialShift,
        ctrlHeld, breakCtrl, specialCtrl
    } TranslatorState_t;

    TranslatorState_t state, nextState;

    logic special, shift, ctrl;
    logic emitEnable, decoderValid;
    logic isShiftKey, isCtrlKey, isBreak, isSpecial;

    assign isShiftKey = (scancode == LeftShiftCode) || (scancode == RightShiftCode);
    assign isCtrlKey = (scancode == LeftCtrlCode);
    assign isBreak = (scancode == BreakCode);
    assign isSpecial = (scancode == SpecialCode);

    // Full FIFO drops the byte on its own side
    assign fifoWriteRequest = emitEnable & decoderValid;

    ScancodeDecoder i_ScancodeDecoder (
        .scancode,
        .special,
        .shift,
        .ctrl,
        .fifoInData,
        .valid(decoderValid)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= normal;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        emitEnable = 1'b0;
        special = 1'b0;
        shift = 1'b0;
        ctrl = 1'b0;
        if (scancodeDone) begin
            case (state)
                normal: begin
                    if (isShiftKey) nextState = shiftHeld;
                    else if (isCtrlKey) nextState = ctrlHeld;
                    else if (isSpecial) nextState = specialNormal;
                    else if (isBreak) nextState = breakNormal;
                    else emitEnable = 1'b1;
                end
                breakNormal: nextState = normal;
                specialNormal: begin
                    if (isBreak) begin
                        nextState = breakNormal;
                    end else begin
                        nextState = normal;
                        special = 1'b1;
                        emitEnable = 1'b1;
                    end
                end
                shiftHeld: begin
                    if (isSpecial) nextState = specialShift;
                    else if (isBreak) nextState = breakShift;
                    else if (!isShiftKey) begin
                        shift = 1'b1;
                        emitEnable = 1'b1;
                    end
                end
                breakShift: nextState = isShiftKey ? normal : shiftHeld;
                specialShift: begin
                    // Shifted extended keys are decoded but never emitted
                    nextState = isBreak ? breakShift : shiftHeld;
                    shift = !isBreak;
                    special = !isBreak;
                end
                ctrlHeld: begin
                    if (isSpecial) nextState = specialCtrl;
                    else if (isBreak) nextState = breakCtrl;
                    else if (!isCtrlKey) begin
                        ctrl = 1'b1;
                        emitEnable = 1'b1;
                    end
                end
                breakCtrl: nextState = isCtrlKey ? normal : ctrlHeld;
                specialCtrl: begin
                    nextState = isBreak ? breakCtrl : ctrlHeld;
                    ctrl = !isBreak;
                    special = !isBreak;
                end
                default: nextState = normal;
            endcase
        end
    end

endmodule

`default_nettype wire

/* Ps2UartBridge.f */
KeyboardPkg.sv
Ps2Receiver.sv
ScancodeDecoder.sv
Ps2Translator.sv
ByteFifo.sv
UartTransmitter.sv
Ps2UartBridge.sv
TbClock.sv
Ps2UartBridge_assertions.sv
Ps2UartBridgeTb.sv

/* Ps2UartBridge.sv */
`timescale 1ns/10ps
`default_nettype none

module Ps2UartBridge import KeyboardPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic ps2Clk,
    input  logic ps2Data,
    output logic uartTx,
    output logic ps2Error
);

    Scancode_t     scancode;
    logic          scancodeDone;
    logic          fifoWriteRequest;
    UartFifoData_t fifoInData;
    logic          fifoFull;
    logic          fifoEmpty;
    UartFifoData_t fifoOutData;
    logic          fifoReadRequest;

    Ps2Receiver i_Ps2Receiver (
        .clk,
        .rst,
        .ps2Clk,
        .ps2Data,
        .scancode,
        .scancodeDone,
        .ps2Error
    );

    Ps2Translator i_Ps2Translator (
        .clk,
        .rst,
        .scancodeDone,
        .scancode,
        .fifoFull,
        .fifoWriteRequest,
        .fifoInData
    );

    ByteFifo i_ByteFifo (
        .clk,
        .rst,
        .fifoWriteRequest,
        .fifoInData,
        .fifoReadRequest,
        .fifoOutData,
        .fifoEmpty,
        .fifoFull
    );

    UartTransmitter i_UartTransmitter (
        .clk,
        .rst,
        .fifoEmpty,
        .fifoOutData,
        .fifoReadRequest,
        .uartTx
    );

endmodule

`default_nettype wire

/* Ps2UartBridgeTb.sv */
`timescale 1ns/10ps
`default_nettype none

module Ps2UartBridgeTb import KeyboardPkg::*; ();

    localparam int Ps2HalfPeriod = 20;
    // 88 frames of about 460 cycles, plus drain and slack
    localparam int TimeoutCycles = 60000;

    logic clk;
    logic rst;
    logic ps2Clk;
    logic ps2Data;
    logic uartTx;
    logic ps2Error;
    logic monitorBusy;

    UartFifoData_t expectedBytes[$];
    int seed = 32'hc0e78d12;
    int errorPulses = 0;
    int badFrames = 0;
    int cycleCount = 0;

    // Set 2 make codes, a to z and 0 to 9
    Scancode_t letterCodes[26] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
        8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
        8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
    };
    Scancode_t digitCodes[10] = '{
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
    };

    TbClock i_TbClock (.clk);

    Ps2UartBridge i_Ps2UartBridge (
        .clk,
        .rst,
        .ps2Clk,
        .ps2Data,
        .uartTx,
        .ps2Error
    );

    function automatic UartFifoData_t letterChar(input int index, input logic upper);
        return UartFifoData_t'((upper ? 8'h41 : 8'h61) + index);
    endfunction

    function automatic UartFifoData_t digitChar(input int index);
        return UartFifoData_t'(8'h30 + index);
    endfunction

    function automatic UartFifoData_t ctrlChar(input int index);
        return UartFifoData_t'(index + 1);
    endfunction

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic holdCycles(input int count);
        repeat (count) @(posedge clk);
        #1;
    endtask

    // Start, data LSB first, odd parity, stop
    task automatic sendFrame(input Scancode_t code, input logic badParity);
        logic [10:0] frame;
        frame = {1'b1, (~^code) ^ badParity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2Data = frame[i];
            holdCycles(Ps2HalfPeriod);
            ps2Clk = 1'b0;
            holdCycles(Ps2HalfPeriod);
            ps2Clk = 1'b1;
        end
        if (badParity) begin
            badFrames++;
        end
        holdCycles(Ps2HalfPeriod);
        assert (errorPulses == badFrames)
            else stopWithFailure($sformatf("ERR %0t ps2Error pulses expected %0d received %0d",
                $time, badFrames, errorPulses));
    endtask

    task automatic sendCode(input Scancode_t code);
        sendFrame(code, 1'b0);
    endtask

    task automatic releaseKey(input Scancode_t code);
        sendCode(BreakCode);
        sendCode(code);
    endtask

    task automatic tapKey(input Scancode_t code, input UartFifoData_t expected);
        expectedBytes.push_back(expected);
        sendCode(code);
        releaseKey(code);
    endtask

    task automatic pressArrow(input Scancode_t code, input UartFifoData_t expected);
        expectedBytes.push_back(expected);
        sendCode(SpecialCode);
        sendCode(code);
    endtask

    always @(negedge clk) begin
        if (!rst && ps2Error) begin
            errorPulses++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount == TimeoutCycles) begin
            stopWithFailure("Timeout, the run did not finish within the cycle limit");
        end
    end

    // Samples each UART bit near its middle
    initial begin : uartMonitor
        UartFifoData_t received;
        UartFifoData_t expected;
        logic previousTx;
        previousTx = 1'b1;
        monitorBusy = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && previousTx && !uartTx) begin
                monitorBusy = 1'b1;
                repeat (ClocksPerBit / 2 - 1) @(negedge clk);
                assert (!uartTx) else stopWithFailure("Start bit on uartTx ended early");
                for (int i = 0; i < 8; i++) begin
                    repeat (ClocksPerBit) @(negedge clk);
                    received[i] = uartTx;
                end
                repeat (ClocksPerBit) @(negedge clk);
                assert (uartTx)
                    else stopWithFailure($sformatf("ERR %0t uartTx stop bit expected 1 received 0",
                        $time));
                assert (expectedBytes.size() > 0)
                    else stopWithFailure("A byte arrived on uartTx when none was expected");
                expected = expectedBytes.pop_front();
                assert (received == expected)
                    else stopWithFailure($sformatf("ERR %0t uartTx byte expected %02h received %02h",
                        $time, expected, received));
                monitorBusy = 1'b0;
            end
            previousTx = uartTx;
        end
    end

    initial begin : stimulus
        int index;
        int drainCycles;
        rst = 1'b1;
        ps2Clk = 1'b1;
        ps2Data = 1'b1;
        holdCycles(5);
        rst = 1'b0;
        // Quiet line after reset
        holdCycles(200);

        tapKey(letterCodes[0], letterChar(0, 1'b0));
        tapKey(letterCodes[25], letterChar(25, 1'b0));
        tapKey(digitCodes[5], digitChar(5));
        tapKey(digitCodes[0], digitChar(0));
        tapKey(8'h29, 8'h20);
        tapKey(8'h5A, 8'h0D);

        // Shift held, repeated shift make gives nothing
        sendCode(LeftShiftCode);
        sendCode(LeftShiftCode);
        expectedBytes.push_back(letterChar(1, 1'b1));
        sendCode(letterCodes[1]);
        releaseKey(letterCodes[1]);
        releaseKey(LeftShiftCode);
        tapKey(letterCodes[1], letterChar(1, 1'b0));
        sendCode(RightShiftCode);
        expectedBytes.push_back(letterChar(0, 1'b1));
        sendCode(letterCodes[0]);
        releaseKey(RightShiftCode);

        sendCode(LeftCtrlCode);
        expectedBytes.push_back(ctrlChar(2));
        sendCode(letterCodes[2]);
        releaseKey(letterCodes[2]);
        releaseKey(LeftCtrlCode);
        tapKey(letterCodes[2], letterChar(2, 1'b0));

        pressArrow(ArrowUpCode, 8'h11);
        sendCode(SpecialCode);
        releaseKey(ArrowUpCode);
        pressArrow(ArrowDownCode, 8'h12);
        pressArrow(ArrowLeftCode, 8'h13);
        pressArrow(ArrowRightCode, 8'h14);

        // Extended keys under a modifier are dropped, modifier stays
        sendCode(LeftShiftCode);
        sendCode(SpecialCode);
        sendCode(ArrowRightCode);
        expectedBytes.push_back(letterChar(0, 1'b1));
        sendCode(letterCodes[0]);
        releaseKey(LeftShiftCode);
        sendCode(LeftCtrlCode);
        sendCode(SpecialCode);
        sendCode(ArrowUpCode);
        expectedBytes.push_back(ctrlChar(0));
        sendCode(letterCodes[0]);
        releaseKey(LeftCtrlCode);

        sendFrame(letterCodes[0], 1'b1);
        tapKey(letterCodes[0], letterChar(0, 1'b0));

        // Random make codes, no break in between
        repeat (20) begin
            index = $unsigned($random(seed)) % 26;
            expectedBytes.push_back(letterChar(index, 1'b0));
            sendCode(letterCodes[index]);
        end

        drainCycles = 0;
        while (expectedBytes.size() != 0 && drainCycles < 40 * ClocksPerBit) begin
            holdCycles(1);
            drainCycles++;
        end
        holdCycles(10 * ClocksPerBit);

        if (expectedBytes.size() == 0 && uartTx && !monitorBusy) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            stopWithFailure($sformatf("Characters missing on uartTx, %0d bytes never arrived",
                expectedBytes.size()));
        end
    end

endmodule

`default_nettype wire

/* Ps2UartBridge_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module Ps2UartBridgeAssertions import KeyboardPkg::*; (
    input logic clk,
    input logic rst,
    input logic uartTx,
    input logic ps2Error,
    input logic scancodeDone,
    input logic fifoWriteRequest,
    input logic fifoFull
);

    logic [BaudWidth:0] lowCycles;

    // Length of the current low run on the line, saturates at one bit time
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lowCycles <= '0;
        end else if (uartTx) begin
            lowCycles <= '0;
        end else if (lowCycles < (BaudWidth + 1)'(ClocksPerBit)) begin
            lowCycles <= lowCycles + 1'b1;
        end
    end

    ResetLineIdle: assert property (@(posedge clk) rst |-> uartTx)
        else $error("uartTx low during reset");

    NoWriteWhenFull: assert property (@(posedge clk) disable iff (rst)
        fifoWriteRequest |-> !fifoFull)
        else $error("FIFO write while full");

    DoneOrError: assert property (@(posedge clk) disable iff (rst)
        !(ps2Error && scancodeDone))
        else $error("ps2Error and scancodeDone in the same cycle");

    StartBitLength: assert property (@(posedge clk) disable iff (rst)
        $rose(uartTx) |-> lowCycles >= (BaudWidth + 1)'(ClocksPerBit))
        else $error("Start bit shorter than one bit time");

endmodule

bind Ps2UartBridge Ps2UartBridgeAssertions i_Ps2UartBridgeAssertions (
    .clk(clk),
    .rst(rst),
    .uartTx(uartTx),
    .ps2Error(ps2Error),
    .scancodeDone(scancodeDone),
    .fifoWriteRequest(fifoWriteRequest),
    .fifoFull(fifoFull)
);

`default_nettype wire

/* ScancodeDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module ScancodeDecoder import KeyboardPkg::*; (
    input  Scancode_t     scancode,
    input  logic          special,
    input  logic          shift,
    input  logic          ctrl,
    output UartFifoData_t fifoInData,
    output logic          valid
);

    UartFifoData_t plainCode;
    UartFifoData_t arrowCode;
    logic          isLetter;

    assign isLetter = (plainCode >= 8'h61) && (plainCode <= 8'h7A);

    // Lower-case letters, digits, space and enter
    always_comb begin
        case (scancode)
            8'h1C: plainCode = 8'h61;
            8'h32: plainCode = 8'h62;
            8'h21: plainCode = 8'h63;
            8'h23: plainCode = 8'h64;
            8'h24: plainCode = 8'h65;
            8'h2B: plainCode = 8'h66;
            8'h34: plainCode = 8'h67;
            8'h33: plainCode = 8'h68;
            8'h43: plainCode = 8'h69;
            8'h3B: plainCode = 8'h6A;
            8'h42: plainCode = 8'h6B;
            8'h4B: plainCode = 8'h6C;
            8'h3A: plainCode = 8'h6D;
            8'h31: plainCode = 8'h6E;
            8'h44: plainCode = 8'h6F;
            8'h4D: plainCode = 8'h70;
            8'h15: plainCode = 8'h71;
            8'h2D: plainCode = 8'h72;
            8'h1B: plainCode = 8'h73;
            8'h2C: plainCode = 8'h74;
            8'h3C: plainCode = 8'h75;
            8'h2A: plainCode = 8'h76;
            8'h1D: plainCode = 8'h77;
            8'h22: plainCode = 8'h78;
            8'h35: plainCode = 8'h79;
            8'h1A: plainCode = 8'h7A;
            8'h45: plainCode = 8'h30;
            8'h16: plainCode = 8'h31;
            8'h1E: plainCode = 8'h32;
            8'h26: plainCode = 8'h33;
            8'h25: plainCode = 8'h34;
            8'h2E: plainCode = 8'h35;
            8'h36: plainCode = 8'h36;
            8'h3D: plainCode = 8'h37;
            8'h3E: plainCode = 8'h38;
            8'h46: plainCode = 8'h39;
            8'h29: plainCode = 8'h20;
            8'h5A: plainCode = 8'h0D;
            default: plainCode = '0;
        endcase
    end

    always_comb begin
        case (scancode)
            ArrowUpCode: arrowCode = 8'h11;
            ArrowDownCode: arrowCode = 8'h12;
            ArrowLeftCode: arrowCode = 8'h13;
            ArrowRightCode: arrowCode = 8'h14;
            default: arrowCode = '0;
        endcase
    end

    always_comb begin
        fifoInData = plainCode;
        valid = (plainCode != '0);
        if (special) begin
            // Arrows only, and never with a modifier held
            fifoInData = arrowCode;
            valid = (arrowCode != '0) && !shift && !ctrl;
        end else if (isLetter && ctrl) begin
            fifoInData = plainCode - 8'h60;
        end else if (isLetter && shift) begin
            fifoInData = plainCode - 8'h20;
        end
    end

endmodule

`default_nettype wire

/* TbClock.sv */
`timescale 1ns/10ps
`default_nettype none

module TbClock (
    output logic clk
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

endmodule

`default_nettype wire

/* UartTransmitter.sv */
`timescale 1ns/10ps
`default_nettype none

module UartTransmitter import KeyboardPkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          fifoEmpty,
    input  UartFifoData_t fifoOutData,
    output logic          fifoReadRequest,
    output logic          uartTx
);

    typedef enum logic [1:0] {idle, startBit, dataBits, stopBit} TxState_t;

    TxState_t             state;
    UartFifoData_t        txByte;
    logic [BaudWidth-1:0] baudCount;
    logic [2:0]           bitIndex;
    logic                 bitEnd;

    assign fifoReadRequest = (state == idle) && !fifoEmpty;
    assign bitEnd = (baudCount == BaudWidth'(ClocksPerBit - 1));

    always_ff @(posedge clk) begin
        if (fifoReadRequest) begin
            txByte <= fifoOutData;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
            uartTx <= 1'b1;
            baudCount <= '0;
            bitIndex <= '0;
        end else if (state == idle) begin
            baudCount <= '0;
            bitIndex <= '0;
            if (!fifoEmpty) begin
                state <= startBit;
                uartTx <= 1'b0;
            end
        end else if (!bitEnd) begin
            baudCount <= baudCount + 1'b1;
        end else begin
            baudCount <= '0;
            case (state)
                startBit: begin
                    state <= dataBits;
                    uartTx <= txByte[0];
                end
                dataBits: begin
                    // LSB first, stop bit after the eighth
                    if (bitIndex == 3'd7) begin
                        state <= stopBit;
                        uartTx <= 1'b1;
                    end else begin
                        bitIndex <= bitIndex + 3'd1;
                        uartTx <= txByte[bitIndex + 3'd1];
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire
